// ==== run_sim.sh ====
#!/bin/sh
# build and run the tone generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -f sim.f --top-module tb_tone_top -o tb_tone_top \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_tone_top > sim.log 2>&1
cat sim.log

grep -qx 'All tests passed!' sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== sim.f ====
src/tone_pkg.sv
src/sine_table.sv
src/table_arbiter.sv
src/tone_voice.sv
src/tone_sequencer.sv
src/tone_top.sv
tests/tone_top_chk.sv
tests/tb_tone_top.sv

// ==== src/sine_table.sv ====
`timescale 1ns/1ps

module sine_table
	import tone_pkg::*;
(
	input  logic    CLOCK_25,
	input  logic    rd_en,
	input  phase_t  rd_addr,
	output sample_t rd_data
);

	localparam int DEPTH = 256;

	// ========================================
	// rom contents
	// ========================================

	// one entry per phase index
	sample_t rom [DEPTH];

	// every entry is a constant from the package rule
	genvar i;
	generate
		for (i = 0; i < DEPTH; i++) begin : g_entry
			localparam sample_t ENTRY = sine_value(phase_t'(i));
			assign rom[i] = ENTRY;
		end
	endgenerate

	// ========================================
	// registered read
	// ========================================

	// data shows up the cycle after rd_en
	always_ff @(posedge CLOCK_25) begin
		if (rd_en) begin
			rd_data <= rom[rd_addr];
		end
	end

	// old value stays on the port while idle
	// so a late reader still sees the last sample

endmodule

// ==== src/table_arbiter.sv ====
`timescale 1ns/1ps

module table_arbiter
	import tone_pkg::*;
(
	input  logic    CLOCK_25,
	input  logic    reset,
	// voice 0 request side
	input  logic    req_valid_0,
	input  phase_t  req_phase_0,
	output logic    req_ready_0,
	output logic    resp_valid_0,
	// voice 1 request side
	input  logic    req_valid_1,
	input  phase_t  req_phase_1,
	output logic    req_ready_1,
	output logic    resp_valid_1,
	// read data goes to both, strobe picks the owner
	output sample_t resp_data,
	// table port
	output logic    rd_en,
	output phase_t  rd_addr,
	input  sample_t rd_data
);

	// voice that won the last grant
	logic last_grant;

	// grant of this cycle
	logic grant_0;
	logic grant_1;

	// ========================================
	// round robin pick
	// ========================================

	// a lone requester always wins
	// on a tie the voice not granted last goes first
	assign grant_0 = req_valid_0 && (!req_valid_1 || last_grant);
	assign grant_1 = req_valid_1 && (!req_valid_0 || !last_grant);

	assign req_ready_0 = grant_0;
	assign req_ready_1 = grant_1;

	// forward the winning phase to the rom
	assign rd_en   = grant_0 || grant_1;
	assign rd_addr = grant_1 ? req_phase_1 : req_phase_0;

	// ========================================
	// priority and response routing
	// ========================================

	always_ff @(posedge CLOCK_25) begin
		if (reset) begin
			// last_grant high so voice 0 leads after reset
			last_grant   <= 1'b1;
			resp_valid_0 <= 1'b0;
			resp_valid_1 <= 1'b0;
		end else begin
			// rom answers next cycle, strobe the owner then
			resp_valid_0 <= grant_0;
			resp_valid_1 <= grant_1;
			if (grant_0)
				last_grant <= 1'b0;
			else if (grant_1)
				last_grant <= 1'b1;
		end
	end

	// rom output lines up with the strobe
	assign resp_data = rd_data;

endmodule

// ==== src/tone_pkg.sv ====
package tone_pkg;

	// ========================================
	// shared widths
	// ========================================

	// phase index, also the sine table address
	typedef logic [7:0] phase_t;

	// unsigned sine sample, midpoint at 128
	typedef logic [7:0] sample_t;

	// clock cycles between two phase steps
	typedef logic [15:0] div_t;

	// pitch pattern of the sequencer, encoding doubles as pattern_step
	typedef enum logic [1:0] {
		pitch_a = 2'd0,
		pitch_b = 2'd1,
		pitch_c = 2'd2
	} seq_state_t;

	// ========================================
	// sine rule
	// ========================================

	// parabolic half wave, positive lobe for 0..127, negative for 128..255
	function automatic sample_t sine_value(input phase_t idx);
		int h;
		int p;
		h = int'(idx[6:0]);
		p = (h * (128 - h)) / 32;
		// peak of the parabola would reach 128
		if (p > 127)
			p = 127;
		if (idx[7] == 1'b0)
			return sample_t'(128 + p);
		else
			return sample_t'(128 - p);
	endfunction

endpackage

// ==== src/tone_sequencer.sv ====
`timescale 1ns/1ps

module tone_sequencer
	import tone_pkg::*;
#(
	parameter int   STEP_CYCLES = 2000,
	parameter div_t DIV_A       = 16'd9,
	parameter div_t DIV_B       = 16'd5,
	parameter div_t DIV_C       = 16'd7
) (
	input  logic       CLOCK_25,
	input  logic       reset,
	output div_t       div_0,
	output div_t       div_1,
	output logic [1:0] pattern_step,
	output logic       led
);

	seq_state_t state;
	seq_state_t state_next;

	// cycles elapsed in the current step
	logic [31:0] step_count;

	// ========================================
	// step timer and pattern
	// ========================================

	always_ff @(posedge CLOCK_25) begin
		if (reset) begin
			step_count <= '0;
			state      <= pitch_a;
			led        <= 1'b0;
		end else if (step_count == 32'(STEP_CYCLES - 1)) begin
			// end of step, next pitch and flip the led
			step_count <= '0;
			state      <= state_next;
			led        <= ~led;
		end else begin
			step_count <= step_count + 32'd1;
		end
	end

	// a, b, c then back to a
	always_comb begin
		case (state)
			pitch_a: state_next = pitch_b;
			pitch_b: state_next = pitch_c;
			default: state_next = pitch_a;
		endcase
	end

	assign pattern_step = state;

	// ========================================
	// divider per voice
	// ========================================

	// voice 0 plays the current pitch, voice 1 the one ahead
	always_comb begin
		case (state)
			pitch_a: div_0 = DIV_A;
			pitch_b: div_0 = DIV_B;
			default: div_0 = DIV_C;
		endcase
		case (state_next)
			pitch_a: div_1 = DIV_A;
			pitch_b: div_1 = DIV_B;
			default: div_1 = DIV_C;
		endcase
	end

endmodule

// ==== src/tone_top.sv ====
`timescale 1ns/1ps

module tone_top
	import tone_pkg::*;
#(
	parameter int   STEP_CYCLES = 2000,
	parameter div_t DIV_A       = 16'd9,
	parameter div_t DIV_B       = 16'd5,
	parameter div_t DIV_C       = 16'd7
) (
	input  logic       CLOCK_25,
	input  logic       reset,
	// one enable bit per voice
	input  logic [1:0] enable,
	output sample_t    sample_0,
	output sample_t    sample_1,
	output logic       sample_valid_0,
	output logic       sample_valid_1,
	output logic [1:0] pattern_step,
	output logic       led
);

	// dividers from the sequencer
	div_t div_0;
	div_t div_1;

	// voice to arbiter
	logic   req_valid_0;
	logic   req_valid_1;
	logic   req_ready_0;
	logic   req_ready_1;
	phase_t req_phase_0;
	phase_t req_phase_1;

	// arbiter back to voices
	logic    resp_valid_0;
	logic    resp_valid_1;
	sample_t resp_data;

	// arbiter to rom
	logic    rd_en;
	phase_t  rd_addr;
	sample_t rd_data;

	// ========================================
	// pitch pattern
	// ========================================

	tone_sequencer #(
		.STEP_CYCLES (STEP_CYCLES),
		.DIV_A       (DIV_A),
		.DIV_B       (DIV_B),
		.DIV_C       (DIV_C)
	) u_seq (
		.CLOCK_25     (CLOCK_25),
		.reset        (reset),
		.div_0        (div_0),
		.div_1        (div_1),
		.pattern_step (pattern_step),
		.led          (led)
	);

	// ========================================
	// voices
	// ========================================

	tone_voice u_voice_0 (
		.CLOCK_25     (CLOCK_25),
		.reset        (reset),
		.enable       (enable[0]),
		.div          (div_0),
		.req_valid    (req_valid_0),
		.req_ready    (req_ready_0),
		.req_phase    (req_phase_0),
		.resp_valid   (resp_valid_0),
		.resp_data    (resp_data),
		.sample       (sample_0),
		.sample_valid (sample_valid_0)
	);

	tone_voice u_voice_1 (
		.CLOCK_25     (CLOCK_25),
		.reset        (reset),
		.enable       (enable[1]),
		.div          (div_1),
		.req_valid    (req_valid_1),
		.req_ready    (req_ready_1),
		.req_phase    (req_phase_1),
		.resp_valid   (resp_valid_1),
		.resp_data    (resp_data),
		.sample       (sample_1),
		.sample_valid (sample_valid_1)
	);

	// ========================================
	// shared sine table
	// ========================================

	table_arbiter u_arb (
		.CLOCK_25     (CLOCK_25),
		.reset        (reset),
		.req_valid_0  (req_valid_0),
		.req_phase_0  (req_phase_0),
		.req_ready_0  (req_ready_0),
		.resp_valid_0 (resp_valid_0),
		.req_valid_1  (req_valid_1),
		.req_phase_1  (req_phase_1),
		.req_ready_1  (req_ready_1),
		.resp_valid_1 (resp_valid_1),
		.resp_data    (resp_data),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data)
	);

	sine_table u_table (
		.CLOCK_25 (CLOCK_25),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

endmodule

// ==== src/tone_voice.sv ====
`timescale 1ns/1ps

module tone_voice
	import tone_pkg::*;
(
	input  logic    CLOCK_25,
	input  logic    reset,
	input  logic    enable,
	// cycles per phase step
	input  div_t    div,
	// table request
	output logic    req_valid,
	input  logic    req_ready,
	output phase_t  req_phase,
	// table response
	input  logic    resp_valid,
	input  sample_t resp_data,
	// sample out
	output sample_t sample,
	output logic    sample_valid
);

	typedef enum logic [1:0] {
		counting,
		requesting,
		awaiting
	} voice_state_t;

	voice_state_t state;

	// divider, frozen while a request is open
	div_t count;

	// current table index
	phase_t phase;

	// last returned sample
	sample_t sample_q;

	// ========================================
	// request side
	// ========================================

	// valid and phase held steady until accepted
	assign req_valid = (state == requesting);
	assign req_phase = phase;

	// ========================================
	// divider and request fsm
	// ========================================

	always_ff @(posedge CLOCK_25) begin
		if (reset) begin
			state    <= counting;
			count    <= '0;
			phase    <= '0;
			sample_q <= '0;
		end else begin
			case (state)
				counting: begin
					// disabled voice keeps its count and phase
					if (enable) begin
						// counter lands on zero as req_valid rises
						if (count <= div_t'(1)) begin
							count <= '0;
							state <= requesting;
						end else begin
							count <= count - div_t'(1);
						end
					end
				end
				requesting: begin
					if (req_valid && req_ready)
						state <= awaiting;
				end
				awaiting: begin
					// sample landed, step phase and restart divider
					if (resp_valid) begin
						state    <= counting;
						count    <= div - div_t'(1);
						phase    <= phase + phase_t'(1);
						sample_q <= resp_data;
					end
				end
				default: state <= counting;
			endcase
		end
	end

	// ========================================
	// sample out
	// ========================================

	// strobe on the response cycle itself
	assign sample_valid = (state == awaiting) && resp_valid;

	// fresh data passes straight through on the strobe
	assign sample = sample_valid ? resp_data : sample_q;

endmodule

// ==== tests/tb_tone_top.sv ====
`timescale 1ns/1ps

module tb_tone_top
	import tone_pkg::*;
;

	logic       CLOCK_25;
	logic       reset;
	logic [1:0] enable;
	sample_t    sample_0;
	sample_t    sample_1;
	logic       sample_valid_0;
	logic       sample_valid_1;
	logic [1:0] pattern_step;
	logic       led;

	// model state kept by the monitor
	int     cyc;
	int     errors;
	int     checks;
	int     step;
	int     step_changes;
	int     last_change;
	int     last_pattern;
	logic   last_led;
	logic   monitor_on;
	logic   both_full;
	phase_t exp_phase [2];
	int     last_sample [2];
	int     pat_at_sample [2];
	int     low_run [2];
	int     step_samples [2];
	logic   have_last [2];
	logic   clean [2];

	// lfsr for the enable pattern
	logic [31:0] lfsr_state;

	tone_top u_dut (
		.CLOCK_25       (CLOCK_25),
		.reset          (reset),
		.enable         (enable),
		.sample_0       (sample_0),
		.sample_1       (sample_1),
		.sample_valid_0 (sample_valid_0),
		.sample_valid_1 (sample_valid_1),
		.pattern_step   (pattern_step),
		.led            (led)
	);

	// 20 ns period
	always #10 CLOCK_25 = ~CLOCK_25;

	// ========================================
	// model helpers
	// ========================================

	// parabola per half wave h*(128-h)/32 clamped to 127
	function automatic sample_t model_sine(input phase_t idx);
		int h;
		int p;
		h = int'(idx) % 128;
		p = (h * (128 - h)) / 32;
		if (p > 127)
			p = 127;
		if (int'(idx) < 128)
			return sample_t'(128 + p);
		return sample_t'(128 - p);
	endfunction

	// divider of a pitch read back from the dut parameters
	function automatic int divider_of(input int pat);
		case (pat)
			0: return int'(u_dut.DIV_A);
			1: return int'(u_dut.DIV_B);
			default: return int'(u_dut.DIV_C);
		endcase
	endfunction

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// ========================================
	// per voice checks
	// ========================================

	task automatic check_voice(input int k, input logic v, input sample_t s, input logic en);
		int      div;
		int      gap;
		sample_t exp;
		// voice 1 runs one pitch ahead
		div = divider_of((pat_at_sample[k] + k) % 3);
		if (en)
			low_run[k] = 0;
		else
			low_run[k]++;
		if (v) begin
			checks++;
			exp = model_sine(exp_phase[k]);
			if (s !== exp) begin
				$display("FAILED at %0t: sample_%0d expected %0d got %0d", $time, k, exp, s);
				errors++;
			end
			if (low_run[k] > 3) begin
				$display("FAILED at %0t: sample_valid_%0d expected 0 got 1", $time, k);
				errors++;
			end
			if (have_last[k] && clean[k]) begin
				gap = cyc - last_sample[k];
				if (gap < div + 1 || gap > div + 2) begin
					$display("FAILED at %0t: sample_valid_%0d gap expected %0d..%0d got %0d",
						$time, k, div + 1, div + 2, gap);
					errors++;
				end
			end
			exp_phase[k]     = exp_phase[k] + phase_t'(1);
			last_sample[k]   = cyc;
			pat_at_sample[k] = int'(pattern_step);
			have_last[k]     = 1'b1;
			clean[k]         = 1'b1;
			step_samples[k]++;
		end else if (have_last[k] && clean[k] && cyc - last_sample[k] > div + 2) begin
			$display("voice %0d went more than %0d cycles without a sample at %0t",
				k, div + 2, $time);
			errors++;
			clean[k] = 1'b0;
		end
		// gap only counts over an enabled stretch at one pitch
		if (!en || int'(pattern_step) != pat_at_sample[k])
			clean[k] = 1'b0;
	endtask

	// step period, order, led, and sample counts over a full step
	task automatic check_pattern();
		int k;
		int min_count;
		if (int'(pattern_step) != last_pattern) begin
			checks++;
			if (cyc - last_change != step) begin
				$display("FAILED at %0t: pattern_step period expected %0d got %0d",
					$time, step, cyc - last_change);
				errors++;
			end
			if (int'(pattern_step) != (last_pattern + 1) % 3) begin
				$display("FAILED at %0t: pattern_step expected %0d got %0d",
					$time, (last_pattern + 1) % 3, pattern_step);
				errors++;
			end
			if (led !== ~last_led) begin
				$display("FAILED at %0t: led expected %0b got %0b", $time, ~last_led, led);
				errors++;
			end
			for (k = 0; k < 2; k++) begin
				min_count = step / (divider_of((last_pattern + k) % 3) + 2);
				if (both_full && step_samples[k] < min_count) begin
					$display("FAILED at %0t: sample_valid_%0d count expected >= %0d got %0d",
						$time, k, min_count, step_samples[k]);
					errors++;
				end
				step_samples[k] = 0;
			end
			both_full    = 1'b1;
			last_change  = cyc;
			last_pattern = int'(pattern_step);
			last_led     = led;
			step_changes++;
		end else if (led !== last_led) begin
			$display("FAILED at %0t: led expected %0b got %0b", $time, last_led, led);
			errors++;
			last_led = led;
		end
	endtask

	// ========================================
	// monitor at the falling edge
	// ========================================

	always @(negedge CLOCK_25) begin
		if (reset) begin
			cyc          = 0;
			errors       = 0;
			checks       = 0;
			step         = u_dut.STEP_CYCLES;
			step_changes = 0;
			monitor_on   = 1'b0;
			both_full    = 1'b1;
			for (int k = 0; k < 2; k++) begin
				exp_phase[k]     = '0;
				last_sample[k]   = 0;
				pat_at_sample[k] = 0;
				low_run[k]       = 0;
				step_samples[k]  = 0;
				have_last[k]     = 1'b0;
				clean[k]         = 1'b0;
			end
		end else begin
			if (!monitor_on) begin
				// first cycle out of reset
				monitor_on   = 1'b1;
				last_change  = cyc;
				last_pattern = 0;
				last_led     = 1'b0;
				checks++;
				if (led !== 1'b0) begin
					$display("FAILED at %0t: led expected 0 got %0b", $time, led);
					errors++;
				end
				if (pattern_step !== 2'd0) begin
					$display("FAILED at %0t: pattern_step expected 0 got %0d",
						$time, pattern_step);
					errors++;
				end
			end
			check_pattern();
			if (enable != 2'b11)
				both_full = 1'b0;
			check_voice(0, sample_valid_0, sample_0, enable[0]);
			check_voice(1, sample_valid_1, sample_1, enable[1]);
		end
		cyc++;
	end

	// ========================================
	// stimulus
	// ========================================

	initial begin : main
		logic b1;
		logic b0;
		CLOCK_25   = 1'b0;
		reset      = 1'b1;
		enable     = 2'b11;
		lfsr_state = 32'hb2123f45;
		repeat (3) @(posedge CLOCK_25);
		reset <= 1'b0;
		// both voices on for the two fairness steps
		wait (step_changes >= 2);
		// then random enables every 50 cycles
		while (step_changes < 5) begin
			repeat (50) @(posedge CLOCK_25);
			lfsr_state = lfsr_next(lfsr_state);
			b1 = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
			b0 = lfsr_state[0];
			enable <= {b1, b0};
		end
		$display("run complete: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// six steps of 20 ns cycles against a run of just over five
	initial begin : watchdog
		longint limit;
		limit = 6 * longint'(u_dut.STEP_CYCLES) * 20;
		#(limit);
		$display("watchdog expired after %0d ns: %0d checks, %0d errors", limit, checks, errors);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== tests/tone_top_chk.sv ====
`timescale 1ns/1ps

module tone_top_chk
	import tone_pkg::*;
(
	input logic   CLOCK_25,
	input logic   reset,
	input logic   req_valid_0,
	input phase_t req_phase_0,
	input logic   req_ready_0,
	input logic   resp_valid_0,
	input logic   req_valid_1,
	input phase_t req_phase_1,
	input logic   req_ready_1,
	input logic   resp_valid_1
);

	// ========================================
	// grant
	// ========================================

	// one requester per cycle
	a_one_ready: assert property (@(posedge CLOCK_25) disable iff (reset)
		!(req_ready_0 && req_ready_1))
		else $error("req_ready high for both voices");

	// ========================================
	// response timing
	// ========================================

	// accepted request answered next cycle
	a_resp_0: assert property (@(posedge CLOCK_25) disable iff (reset)
		(req_valid_0 && req_ready_0) |=> resp_valid_0)
		else $error("voice 0 accept without resp_valid");
	a_resp_1: assert property (@(posedge CLOCK_25) disable iff (reset)
		(req_valid_1 && req_ready_1) |=> resp_valid_1)
		else $error("voice 1 accept without resp_valid");

	// and no strobe without an accept
	a_only_0: assert property (@(posedge CLOCK_25) disable iff (reset)
		resp_valid_0 |-> $past(req_valid_0 && req_ready_0))
		else $error("voice 0 resp_valid without accept");
	a_only_1: assert property (@(posedge CLOCK_25) disable iff (reset)
		resp_valid_1 |-> $past(req_valid_1 && req_ready_1))
		else $error("voice 1 resp_valid without accept");

	// ========================================
	// request hold
	// ========================================

	a_hold_0: assert property (@(posedge CLOCK_25) disable iff (reset)
		(req_valid_0 && !req_ready_0) |=> (req_valid_0 && $stable(req_phase_0)))
		else $error("voice 0 request dropped or changed while waiting");
	a_hold_1: assert property (@(posedge CLOCK_25) disable iff (reset)
		(req_valid_1 && !req_ready_1) |=> (req_valid_1 && $stable(req_phase_1)))
		else $error("voice 1 request dropped or changed while waiting");

endmodule

bind table_arbiter tone_top_chk u_chk (
	.CLOCK_25     (CLOCK_25),
	.reset        (reset),
	.req_valid_0  (req_valid_0),
	.req_phase_0  (req_phase_0),
	.req_ready_0  (req_ready_0),
	.resp_valid_0 (resp_valid_0),
	.req_valid_1  (req_valid_1),
	.req_phase_1  (req_phase_1),
	.req_ready_1  (req_ready_1),
	.resp_valid_1 (resp_valid_1)
);
